//--- mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

////////////////////////////////////////////////////////////
// Memory subsystem widths
////////////////////////////////////////////////////////////

// SRAM word address
`define MEM_ADDR_W 18
// SRAM word and instruction width
`define MEM_DATA_W 16
// Processor step token
`define ACT_W 32
// First fetch address after reset
`define FETCH_START 18'h0_0000

`endif

//--- mem_pkg.sv
`include "mem_cfg.svh"

package mem_pkg;

	////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////

	typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [`MEM_DATA_W-1:0] mem_word_t;
	typedef logic [`ACT_W-1:0] act_t;

	// Controller states, three per access kind
	typedef enum logic [3:0] {
		IDLE,
		EXE_RD1,
		EXE_RD2,
		EXE_RD3,
		IF_RD1,
		IF_RD2,
		IF_RD3,
		EXE_WR1,
		EXE_WR2,
		EXE_WR3
	} ram_state_t;

	// Execute stage request, held until exe_done
	typedef struct packed {
		logic      valid;
		logic      rd;
		logic      wr;
		mem_addr_t addr;
		mem_word_t wdata;
	} exe_req_t;

endpackage

//--- sram_ctrl.sv
`timescale 1ns/1ns

module sram_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  mem_pkg::act_t       mem_act,
	output mem_pkg::act_t       act_served,
	input  mem_pkg::exe_req_t   exe_req,
	input  mem_pkg::mem_addr_t  if_addr,
	output logic                exe_done,
	output logic                if_done,
	output mem_pkg::mem_word_t  exe_result,
	output mem_pkg::mem_word_t  if_result,
	output mem_pkg::mem_addr_t  ram_addr,
	inout  mem_pkg::mem_word_t  ram_data,
	output logic                ram_oe,
	output logic                ram_we,
	output logic                ram_en
);

	mem_pkg::ram_state_t state;
	mem_pkg::ram_state_t state_next;

	// Which kind of access finished last
	logic exe_flag;
	logic if_flag;

	// Registered pin controls, decoded from the next state
	logic bus_drive;
	logic oe_next;
	logic we_next;
	logic drive_next;

	logic exe_path;
	logic token_new;

	////////////////////////////////////////////////////////////
	// Completion against the current token
	////////////////////////////////////////////////////////////

	assign token_new = (mem_act != act_served);

	assign exe_done = exe_flag && (act_served == mem_act);
	assign if_done  = if_flag && (act_served == mem_act);

	////////////////////////////////////////////////////////////
	// Address mux and data bus
	////////////////////////////////////////////////////////////

	// Execute address wins in IDLE; a running access keeps its own
	always_comb begin
		if (state == mem_pkg::IDLE) begin
			exe_path = exe_req.valid;
		end else begin
			exe_path = state inside {mem_pkg::EXE_RD1, mem_pkg::EXE_RD2, mem_pkg::EXE_RD3,
				mem_pkg::EXE_WR1, mem_pkg::EXE_WR2, mem_pkg::EXE_WR3};
		end
	end

	assign ram_addr = exe_path ? exe_req.addr : if_addr;
	assign ram_data = bus_drive ? exe_req.wdata : 'z;

	// Chip stays selected, OE and WE qualify each cycle
	assign ram_en = 1'b0;

	////////////////////////////////////////////////////////////
	// Access sequence
	////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			mem_pkg::IDLE: begin
				if (token_new) begin
					if (exe_req.valid && exe_req.wr) begin
						state_next = mem_pkg::EXE_WR1;
					end else if (exe_req.valid && exe_req.rd) begin
						state_next = mem_pkg::EXE_RD1;
					end else begin
						state_next = mem_pkg::IF_RD1;
					end
				end
			end
			mem_pkg::EXE_RD1: state_next = mem_pkg::EXE_RD2;
			mem_pkg::EXE_RD2: state_next = mem_pkg::EXE_RD3;
			mem_pkg::IF_RD1:  state_next = mem_pkg::IF_RD2;
			mem_pkg::IF_RD2:  state_next = mem_pkg::IF_RD3;
			mem_pkg::EXE_WR1: state_next = mem_pkg::EXE_WR2;
			mem_pkg::EXE_WR2: state_next = mem_pkg::EXE_WR3;
			default:          state_next = mem_pkg::IDLE;
		endcase
	end

	// OE low in read states 2 and 3, WE low in write states 2 and 3
	always_comb begin
		oe_next = !(state_next inside {mem_pkg::EXE_RD2, mem_pkg::EXE_RD3,
			mem_pkg::IF_RD2, mem_pkg::IF_RD3});
		we_next = !(state_next inside {mem_pkg::EXE_WR2, mem_pkg::EXE_WR3});
		drive_next = state_next inside {mem_pkg::EXE_WR1, mem_pkg::EXE_WR2,
			mem_pkg::EXE_WR3};
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state      <= mem_pkg::IDLE;
			act_served <= '0;
			exe_flag   <= 1'b0;
			if_flag    <= 1'b0;
			exe_result <= '0;
			if_result  <= '0;
			ram_oe     <= 1'b1;
			ram_we     <= 1'b1;
			bus_drive  <= 1'b0;
		end else begin
			state     <= state_next;
			ram_oe    <= oe_next;
			ram_we    <= we_next;
			bus_drive <= drive_next;
			case (state)
				mem_pkg::EXE_RD3, mem_pkg::EXE_WR3: begin
					// On a write this captures the word being written
					exe_result <= ram_data;
					act_served <= mem_act;
					exe_flag   <= 1'b1;
					if_flag    <= 1'b0;
				end
				mem_pkg::IF_RD3: begin
					if_result  <= ram_data;
					act_served <= mem_act;
					if_flag    <= 1'b1;
					exe_flag   <= 1'b0;
				end
				default: begin
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	a_oe_we_excl: assert property (@(posedge clk) disable iff (!rst)
		!(!ram_oe && !ram_we))
		else $error("OE and WE low together");

	// Chip output enabled while the controller also drives the bus
	a_no_contention: assert property (@(posedge clk) disable iff (!rst)
		!ram_oe |-> !bus_drive)
		else $error("Bus driven while OE low");

	a_req_kind: assert property (@(posedge clk) disable iff (!rst)
		exe_req.valid |-> (exe_req.rd ^ exe_req.wr))
		else $error("Execute request must be exactly one of rd, wr");

endmodule

//--- fetch_pc.sv
`timescale 1ns/1ns

`include "mem_cfg.svh"

module fetch_pc (
	input  logic                clk,
	input  logic                rst,
	input  logic                if_done,
	input  mem_pkg::mem_word_t  if_result,
	output mem_pkg::mem_addr_t  if_addr,
	output mem_pkg::mem_word_t  instr
);

	////////////////////////////////////////////////////////////
	// Fetch address and instruction latch
	////////////////////////////////////////////////////////////

	// One word per completed fetch, no branches here
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			if_addr <= `FETCH_START;
			instr   <= '0;
		end else if (if_done) begin
			instr   <= if_result;
			if_addr <= if_addr + mem_pkg::mem_addr_t'(1);
		end
	end

endmodule

//--- act_sequencer.sv
`timescale 1ns/1ns

module act_sequencer (
	input  logic           clk,
	input  logic           rst,
	input  logic           exe_done,
	input  logic           if_done,
	output mem_pkg::act_t  mem_act
);

	logic step;

	// Either access result ends the current step
	assign step = exe_done || if_done;

	////////////////////////////////////////////////////////////
	// Token counter
	////////////////////////////////////////////////////////////

	// Starts one ahead of the controller so the first access opens at once
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			mem_act <= mem_pkg::act_t'(1);
		end else if (step) begin
			mem_act <= mem_act + mem_pkg::act_t'(1);
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	a_step_on_done: assert property (@(posedge clk) disable iff (!rst)
		(mem_act != $past(mem_act)) |-> $past(step))
		else $error("Token moved without a done");

	// One access per token, so both results cannot complete together
	a_single_done: assert property (@(posedge clk) disable iff (!rst)
		!(exe_done && if_done))
		else $error("exe_done and if_done together");

	// Done drops once the token has moved on
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
		step |=> !step)
		else $error("Done held longer than one cycle");

endmodule

//--- mem_subsys_top.sv
`timescale 1ns/1ns

module mem_subsys_top (
	input  logic                clk,
	input  logic                rst,
	input  mem_pkg::exe_req_t   exe_req,
	output logic                exe_done,
	output mem_pkg::mem_word_t  exe_result,
	output mem_pkg::mem_word_t  instr,
	output mem_pkg::mem_addr_t  if_addr,
	output mem_pkg::mem_addr_t  ram_addr,
	inout  mem_pkg::mem_word_t  ram_data,
	output logic                ram_oe,
	output logic                ram_we,
	output logic                ram_en
);

	mem_pkg::act_t       mem_act;
	logic                if_done;
	mem_pkg::mem_word_t  if_result;

	////////////////////////////////////////////////////////////
	// Step token
	////////////////////////////////////////////////////////////

	act_sequencer u_seq (
		.clk      (clk),
		.rst      (rst),
		.exe_done (exe_done),
		.if_done  (if_done),
		.mem_act  (mem_act)
	);

	////////////////////////////////////////////////////////////
	// Instruction fetch
	////////////////////////////////////////////////////////////

	fetch_pc u_fetch (
		.clk       (clk),
		.rst       (rst),
		.if_done   (if_done),
		.if_result (if_result),
		.if_addr   (if_addr),
		.instr     (instr)
	);

	////////////////////////////////////////////////////////////
	// SRAM controller
	////////////////////////////////////////////////////////////

	// act_served is only compared inside the controller
	sram_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.mem_act    (mem_act),
		.act_served (),
		.exe_req    (exe_req),
		.if_addr    (if_addr),
		.exe_done   (exe_done),
		.if_done    (if_done),
		.exe_result (exe_result),
		.if_result  (if_result),
		.ram_addr   (ram_addr),
		.ram_data   (ram_data),
		.ram_oe     (ram_oe),
		.ram_we     (ram_we),
		.ram_en     (ram_en)
	);

endmodule

//--- tb_sram_model.sv
`timescale 1ns/1ns

`include "mem_cfg.svh"

module tb_sram_model (
	input  mem_pkg::mem_addr_t  addr,
	inout  mem_pkg::mem_word_t  data,
	input  logic                oe,
	input  logic                we,
	input  logic                en
);

	localparam int DEPTH = 1 << `MEM_ADDR_W;

	mem_pkg::mem_word_t mem [DEPTH];

	////////////////////////////////////////////////////////////
	// Preload with each word set to its address XOR 5a5a
	////////////////////////////////////////////////////////////

	initial begin
		int i;
		for (i = 0; i < DEPTH; i++) begin
			mem[i] = mem_pkg::mem_word_t'(i) ^ 16'h5a5a;
		end
	end

	////////////////////////////////////////////////////////////
	// Asynchronous read and write
	////////////////////////////////////////////////////////////

	// Chip drives the bus only while selected and output enabled
	assign data = (!en && !oe) ? mem[addr] : 'z;

	// Data and address are steady from the first write state,
	// so the word is taken as WE falls
	always @(negedge we) begin
		if (!en) begin
			mem[addr] = data;
		end
	end

endmodule

//--- tb_mem_subsys.sv
`timescale 1ns/1ns

`include "mem_cfg.svh"

module tb_mem_subsys;

	localparam int RESET_CYCLES = 4;
	localparam int N_ENTRIES = 12;
	localparam int MARGIN = 100;
	localparam int DEPTH = 1 << `MEM_ADDR_W;
	localparam logic [31:0] SEED = 32'h1be7_365f;
	// Fetch must pass the word written by the table
	localparam mem_pkg::mem_addr_t FETCH_TARGET = 18'h0_0034;

	typedef struct packed {
		logic               wr;
		mem_pkg::mem_addr_t addr;
		mem_pkg::mem_word_t wdata;
		mem_pkg::mem_word_t expected;
	} entry_t;

	logic                clk;
	logic                rst;
	mem_pkg::exe_req_t   exe_req;
	logic                exe_done;
	mem_pkg::mem_word_t  exe_result;
	mem_pkg::mem_word_t  instr;
	mem_pkg::mem_addr_t  if_addr;
	mem_pkg::mem_addr_t  ram_addr;
	wire mem_pkg::mem_word_t ram_data;
	logic                ram_oe;
	logic                ram_we;
	logic                ram_en;

	entry_t              stim [N_ENTRIES];
	int                  gaps [N_ENTRIES];
	mem_pkg::mem_word_t  mirror [DEPTH];
	mem_pkg::mem_addr_t  fetch_prev;
	int                  cycle_count;
	int                  cycle_limit;

	mem_subsys_top dut (
		.clk        (clk),
		.rst        (rst),
		.exe_req    (exe_req),
		.exe_done   (exe_done),
		.exe_result (exe_result),
		.instr      (instr),
		.if_addr    (if_addr),
		.ram_addr   (ram_addr),
		.ram_data   (ram_data),
		.ram_oe     (ram_oe),
		.ram_we     (ram_we),
		.ram_en     (ram_en)
	);

	tb_sram_model u_sram (
		.addr (ram_addr),
		.data (ram_data),
		.oe   (ram_oe),
		.we   (ram_we),
		.en   (ram_en)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Fail %s: got %h expected %h", name, actual, expected);
			$display("Simulation FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// Reads expect the preload rule or an earlier write
	task automatic load_stimulus();
		stim[0]  = '{1'b0, 18'h0_0100, 16'h0000, 16'h5b5a};
		stim[1]  = '{1'b1, 18'h0_0100, 16'h1234, 16'h0000};
		stim[2]  = '{1'b0, 18'h0_0100, 16'h0000, 16'h1234};
		stim[3]  = '{1'b0, 18'h3_ffff, 16'h0000, 16'ha5a5};
		stim[4]  = '{1'b1, 18'h3_ffff, 16'hbeef, 16'h0000};
		stim[5]  = '{1'b1, 18'h2_0000, 16'h0f0f, 16'h0000};
		stim[6]  = '{1'b0, 18'h3_ffff, 16'h0000, 16'hbeef};
		stim[7]  = '{1'b0, 18'h2_0000, 16'h0000, 16'h0f0f};
		stim[8]  = '{1'b0, 18'h1_0010, 16'h0000, 16'h5a4a};
		// Lands inside the fetch range, picked up later by fetch
		stim[9]  = '{1'b1, 18'h0_0030, 16'hc0de, 16'h0000};
		stim[10] = '{1'b0, 18'h0_0030, 16'h0000, 16'hc0de};
		stim[11] = '{1'b0, 18'h0_0031, 16'h0000, 16'h5a6b};
	endtask

	task automatic preload_mirror();
		int j;
		for (j = 0; j < DEPTH; j++) begin
			mirror[j] = mem_pkg::mem_word_t'(j) ^ 16'h5a5a;
		end
	endtask

	task automatic drive_request(input entry_t e);
		exe_req.valid = 1'b1;
		exe_req.rd    = !e.wr;
		exe_req.wr    = e.wr;
		exe_req.addr  = e.addr;
		exe_req.wdata = e.wr ? e.wdata : '0;
	endtask

	// Request stays up until the done pulse is seen
	task automatic wait_exe_done();
		do begin
			@(negedge clk);
			// A write strobe carries this request's address and word
			if (!ram_we) begin
				compare_value("ram_addr", 32'(ram_addr), 32'(exe_req.addr));
				compare_value("ram_data", 32'(ram_data), 32'(exe_req.wdata));
			end
		end while (!exe_done);
	endtask

	////////////////////////////////////////////////////////////
	// Monitors
	////////////////////////////////////////////////////////////

	// Pin exclusivity on every cycle, fetch order and fetched words
	always @(negedge clk) begin
		compare_value("ram_oe|ram_we", 32'(ram_oe | ram_we), 32'd1);
		if (!rst) begin
			fetch_prev = `FETCH_START;
		end else if (if_addr != fetch_prev) begin
			compare_value("if_addr", 32'(if_addr),
				32'(fetch_prev + mem_pkg::mem_addr_t'(1)));
			compare_value("instr", 32'(instr), 32'(mirror[fetch_prev]));
			fetch_prev = if_addr;
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: run hung, no progress within %0d cycles", cycle_limit);
			$display("Simulation FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int i;
		int gap_sum;
		rst = 1'b0;
		exe_req = '0;
		cycle_count = 0;
		cycle_limit = 1000000;
		void'($urandom(SEED));
		load_stimulus();
		preload_mirror();

		gap_sum = 0;
		for (i = 0; i < N_ENTRIES; i++) begin
			gaps[i] = int'($urandom_range(0, 6));
			gap_sum = gap_sum + gaps[i];
		end
		// Each entry may wait behind one fetch before its own access
		cycle_limit = RESET_CYCLES + N_ENTRIES * 10 + gap_sum
			+ int'(FETCH_TARGET) * 5 + MARGIN;

		// Pin state inside reset
		repeat (2) @(negedge clk);
		compare_value("ram_oe", 32'(ram_oe), 32'd1);
		compare_value("ram_we", 32'(ram_we), 32'd1);
		compare_value("ram_en", 32'(ram_en), 32'd0);
		compare_value("exe_done", 32'(exe_done), 32'd0);
		repeat (RESET_CYCLES - 2) @(negedge clk);
		rst = 1'b1;

		// Fetch alone over the first words
		while (if_addr != mem_pkg::mem_addr_t'(8)) begin
			@(negedge clk);
		end

		for (i = 0; i < N_ENTRIES; i++) begin
			drive_request(stim[i]);
			wait_exe_done();
			if (stim[i].wr) begin
				mirror[stim[i].addr] = stim[i].wdata;
			end else begin
				compare_value("exe_result", 32'(exe_result), 32'(stim[i].expected));
				compare_value("mirror", 32'(mirror[stim[i].addr]),
					32'(stim[i].expected));
			end
			exe_req = '0;
			repeat (gaps[i]) @(negedge clk);
		end

		// Fetch resumes and runs past the written word
		while (if_addr < FETCH_TARGET) begin
			@(negedge clk);
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- compile.f
+incdir+.
mem_pkg.sv
sram_ctrl.sv
fetch_pc.sv
act_sequencer.sv
mem_subsys_top.sv
tb_sram_model.sv
tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f compile.f \
	--top-module tb_mem_subsys \
	--Mdir obj_dir \
	-o tb_mem_subsys

# The log decides the result, so a failing run must not stop the script here
./obj_dir/tb_mem_subsys > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
	echo "run_sim: PASS"
	exit 0
else
	echo "run_sim: FAIL, see sim.log"
	exit 1
fi
